//--- include/fb_defines.svh
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Command stream word width
`define FB_CMD_WIDTH 32

// Color, depth and stencil
`define FB_NUM_BUFFERS 3

// Pixel index width on the memory write port
`define FB_INDEX_WIDTH 20

// Screen coordinate width
`define FB_POS_WIDTH 11

// Stored pixel width
`define FB_PIXEL_WIDTH 16

// Channel whose base address goes to the display
`define FB_COLOR_BUFFER 0

`endif

//--- hw/fb_pkg.sv
`include "fb_defines.svh"

package fb_pkg;

    // Opcode sits in the top four bits of a header word
    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_SET_REG = 4'h1,
        OP_APPLY   = 4'h2
    } fb_opcode_e;

    // Register id of a SET_REG header
    typedef enum logic [3:0] {
        REG_ADDR          = 4'h0,
        REG_CLEAR         = 4'h1,
        REG_MASK          = 4'h2,
        REG_SCISSOR_EN    = 4'h3,
        REG_SCISSOR_START = 4'h4,
        REG_SCISSOR_END   = 4'h5,
        REG_RESOLUTION    = 4'h6
    } fb_reg_e;

    typedef logic [`FB_POS_WIDTH-1:0]   fb_pos_t;
    typedef logic [`FB_INDEX_WIDTH-1:0] fb_index_t;
    typedef logic [`FB_PIXEL_WIDTH-1:0] fb_pixel_t;

    // Render window, common to all buffers
    typedef struct packed {
        logic    scissor_en;
        fb_pos_t start_x;
        fb_pos_t start_y;
        fb_pos_t end_x;
        fb_pos_t end_y;
        fb_pos_t res_x;
        fb_pos_t res_y;
    } fb_window_t;

    typedef enum logic [1:0] {
        CLR_IDLE,
        CLR_WRITE,
        CLR_DONE
    } fb_clear_state_e;

    typedef enum logic [1:0] {
        SYNC_IDLE,
        SYNC_WAIT_UNITS,
        SYNC_SWAP,
        SYNC_RELEASE
    } fb_sync_state_e;

endpackage

//--- hw/fb_unit_if.sv
`timescale 1ns/1ps

// Per-channel link between the decoder, one clear unit and the apply synchroniser
interface fb_unit_if;

    // Single cycle start pulse for this channel
    logic              apply;
    logic              memset;
    fb_pkg::fb_index_t base_addr;
    fb_pkg::fb_pixel_t clear_value;
    logic              write_enable;

    // Single cycle pulse once the channel has finished
    logic              done;

    modport decoder (
        output apply,
        output memset,
        output base_addr,
        output clear_value,
        output write_enable
    );

    modport unit (
        input  apply,
        input  memset,
        input  base_addr,
        input  clear_value,
        input  write_enable,
        output done
    );

    modport sync (
        input  apply,
        input  done
    );

endinterface

//--- hw/fb_cmd_decoder.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_cmd_decoder (
    input  logic                       aclk,
    input  logic                       rst_n,

    input  logic                       cmd_tvalid,
    output logic                       cmd_tready,
    input  logic                       cmd_tlast,
    input  logic [`FB_CMD_WIDTH-1:0]   cmd_tdata,

    fb_unit_if.decoder                 units [`FB_NUM_BUFFERS],
    output fb_pkg::fb_window_t         window,

    output logic                       swap_req,
    output fb_pkg::fb_index_t          color_addr,
    input  logic                       release_apply
);

    fb_pkg::fb_opcode_e                cmd_state;
    fb_pkg::fb_opcode_e                header_op;
    fb_pkg::fb_reg_e                   reg_id;
    logic [1:0]                        reg_buf;
    logic                              beat;
    logic [`FB_NUM_BUFFERS-1:0]        apply_mask;
    logic                              apply_busy;

    logic [`FB_NUM_BUFFERS-1:0]        apply_q;
    logic                              memset_q;
    logic [`FB_NUM_BUFFERS-1:0]        we_q;
    fb_pkg::fb_index_t                 addr_q [`FB_NUM_BUFFERS];
    fb_pkg::fb_pixel_t                 clear_q [`FB_NUM_BUFFERS];

    assign beat       = cmd_tvalid && cmd_tready;
    assign header_op  = fb_pkg::fb_opcode_e'(cmd_tdata[`FB_CMD_WIDTH-1 -: 4]);
    assign apply_mask = cmd_tdata[`FB_NUM_BUFFERS-1:0];
    // An apply with nothing selected and no swap has no one to release it
    assign apply_busy = (|apply_mask) || cmd_tdata[5];
    assign color_addr = addr_q[`FB_COLOR_BUFFER];

    // Control path, header tracking and the apply handshake
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_state  <= fb_pkg::OP_NOP;
            cmd_tready <= 1'b1;
            apply_q    <= '0;
            memset_q   <= 1'b0;
            swap_req   <= 1'b0;
            we_q       <= '1;
            window     <= '0;
        end
        else
        begin
            apply_q  <= '0;
            swap_req <= 1'b0;
            if (release_apply)
            begin
                cmd_tready <= 1'b1;
            end
            if (beat && (cmd_state == fb_pkg::OP_SET_REG))
            begin
                cmd_state <= fb_pkg::OP_NOP;
                case (reg_id)
                    fb_pkg::REG_MASK:
                    begin
                        if (reg_buf < `FB_NUM_BUFFERS)
                        begin
                            we_q[reg_buf] <= cmd_tdata[0];
                        end
                    end
                    fb_pkg::REG_SCISSOR_EN:
                    begin
                        window.scissor_en <= cmd_tdata[0];
                    end
                    fb_pkg::REG_SCISSOR_START:
                    begin
                        window.start_x <= cmd_tdata[0 +: `FB_POS_WIDTH];
                        window.start_y <= cmd_tdata[16 +: `FB_POS_WIDTH];
                    end
                    fb_pkg::REG_SCISSOR_END:
                    begin
                        window.end_x <= cmd_tdata[0 +: `FB_POS_WIDTH];
                        window.end_y <= cmd_tdata[16 +: `FB_POS_WIDTH];
                    end
                    fb_pkg::REG_RESOLUTION:
                    begin
                        window.res_x <= cmd_tdata[0 +: `FB_POS_WIDTH];
                        window.res_y <= cmd_tdata[16 +: `FB_POS_WIDTH];
                    end
                    default:
                    begin
                    end
                endcase
            end
            else if (beat)
            begin
                case (header_op)
                    fb_pkg::OP_SET_REG:
                    begin
                        // A header closing its packet has lost its data word
                        if (!cmd_tlast)
                        begin
                            cmd_state <= fb_pkg::OP_SET_REG;
                        end
                    end
                    fb_pkg::OP_APPLY:
                    begin
                        apply_q    <= apply_mask;
                        memset_q   <= cmd_tdata[4];
                        swap_req   <= cmd_tdata[5];
                        cmd_tready <= !apply_busy;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // Per-buffer address and clear value, plus the latched register target
    always_ff @(posedge aclk)
    begin
        if (beat && (cmd_state == fb_pkg::OP_NOP))
        begin
            reg_id  <= fb_pkg::fb_reg_e'(cmd_tdata[27:24]);
            reg_buf <= cmd_tdata[17:16];
        end
        if (beat && (cmd_state == fb_pkg::OP_SET_REG) && (reg_buf < `FB_NUM_BUFFERS))
        begin
            if (reg_id == fb_pkg::REG_ADDR)
            begin
                addr_q[reg_buf] <= cmd_tdata[`FB_INDEX_WIDTH-1:0];
            end
            if (reg_id == fb_pkg::REG_CLEAR)
            begin
                clear_q[reg_buf] <= cmd_tdata[`FB_PIXEL_WIDTH-1:0];
            end
        end
    end

    for (genvar i = 0; i < `FB_NUM_BUFFERS; i++)
    begin : g_unit_drive
        assign units[i].apply        = apply_q[i];
        assign units[i].memset       = memset_q;
        assign units[i].base_addr    = addr_q[i];
        assign units[i].clear_value  = clear_q[i];
        assign units[i].write_enable = we_q[i];
    end

endmodule

//--- hw/fb_clear_unit.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_clear_unit (
    input  logic               aclk,
    input  logic               rst_n,

    fb_unit_if.unit            unit,
    input  fb_pkg::fb_window_t window,

    output logic               mem_wvalid,
    output fb_pkg::fb_index_t  mem_waddr,
    output fb_pkg::fb_pixel_t  mem_wdata,
    input  logic               mem_wready
);

    fb_pkg::fb_clear_state_e       state;
    fb_pkg::fb_pos_t               x_lo;
    fb_pkg::fb_pos_t               x_hi;
    fb_pkg::fb_pos_t               y_lo;
    fb_pkg::fb_pos_t               y_hi;
    fb_pkg::fb_pos_t               x;
    fb_pkg::fb_pos_t               y;
    fb_pkg::fb_pos_t               x_next;
    fb_pkg::fb_pos_t               y_next;
    logic                          empty;
    logic                          have_more;
    logic                          load;
    logic                          accept;
    logic [2*`FB_POS_WIDTH-1:0]    row_off;
    fb_pkg::fb_index_t             pixel_addr;

    // Clear rectangle with exclusive upper bounds
    always_comb
    begin
        x_lo = window.scissor_en ? window.start_x : '0;
        y_lo = window.scissor_en ? window.start_y : '0;
        x_hi = window.res_x;
        y_hi = window.res_y;
        if (window.scissor_en && (window.end_x < window.res_x))
        begin
            x_hi = window.end_x;
        end
        if (window.scissor_en && (window.end_y < window.res_y))
        begin
            y_hi = window.end_y;
        end
    end

    assign empty      = (x_lo >= x_hi) || (y_lo >= y_hi);
    assign x_next     = x + 1'b1;
    assign y_next     = y + 1'b1;
    assign accept     = mem_wvalid && mem_wready;
    // Output register refills whenever it is empty or being drained
    assign load       = (state == fb_pkg::CLR_WRITE) && have_more && (!mem_wvalid || mem_wready);
    assign row_off    = y * window.res_x;
    assign pixel_addr = unit.base_addr + row_off[`FB_INDEX_WIDTH-1:0] + `FB_INDEX_WIDTH'(x);
    assign unit.done  = (state == fb_pkg::CLR_DONE);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= fb_pkg::CLR_IDLE;
            mem_wvalid <= 1'b0;
            have_more  <= 1'b0;
            x          <= '0;
            y          <= '0;
        end
        else
        begin
            case (state)
                fb_pkg::CLR_IDLE:
                begin
                    if (unit.apply)
                    begin
                        x <= x_lo;
                        y <= y_lo;
                        if (unit.memset && unit.write_enable && !empty)
                        begin
                            state     <= fb_pkg::CLR_WRITE;
                            have_more <= 1'b1;
                        end
                        else
                        begin
                            state <= fb_pkg::CLR_DONE;
                        end
                    end
                end
                fb_pkg::CLR_WRITE:
                begin
                    if (load)
                    begin
                        mem_wvalid <= 1'b1;
                        // Row by row with x fastest
                        if (x_next == x_hi)
                        begin
                            x <= x_lo;
                            y <= y_next;
                            if (y_next == y_hi)
                            begin
                                have_more <= 1'b0;
                            end
                        end
                        else
                        begin
                            x <= x_next;
                        end
                    end
                    else if (accept)
                    begin
                        mem_wvalid <= 1'b0;
                    end
                    if (!have_more && accept)
                    begin
                        state <= fb_pkg::CLR_DONE;
                    end
                end
                default:
                begin
                    state <= fb_pkg::CLR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (load)
        begin
            mem_waddr <= pixel_addr;
            mem_wdata <= unit.clear_value;
        end
    end

endmodule

//--- hw/fb_apply_sync.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_apply_sync (
    input  logic      aclk,
    input  logic      rst_n,

    fb_unit_if.sync   units [`FB_NUM_BUFFERS],

    input  logic      swap_req,
    output logic      swap_fb,
    input  logic      fb_swapped,
    output logic      release_apply
);

    fb_pkg::fb_sync_state_e        state;
    logic [`FB_NUM_BUFFERS-1:0]    apply_vec;
    logic [`FB_NUM_BUFFERS-1:0]    done_vec;
    logic [`FB_NUM_BUFFERS-1:0]    pending;
    logic [`FB_NUM_BUFFERS-1:0]    remaining;
    logic                          swap_pending;

    for (genvar i = 0; i < `FB_NUM_BUFFERS; i++)
    begin : g_collect
        assign apply_vec[i] = units[i].apply;
        assign done_vec[i]  = units[i].done;
    end

    assign remaining     = pending & ~done_vec;
    assign release_apply = (state == fb_pkg::SYNC_RELEASE);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= fb_pkg::SYNC_IDLE;
            pending      <= '0;
            swap_pending <= 1'b0;
            swap_fb      <= 1'b0;
        end
        else
        begin
            swap_fb <= 1'b0;
            case (state)
                fb_pkg::SYNC_IDLE:
                begin
                    if ((|apply_vec) || swap_req)
                    begin
                        pending      <= apply_vec;
                        swap_pending <= swap_req;
                        state        <= fb_pkg::SYNC_WAIT_UNITS;
                    end
                end
                fb_pkg::SYNC_WAIT_UNITS:
                begin
                    pending <= remaining;
                    if (remaining == '0)
                    begin
                        swap_fb <= swap_pending;
                        state   <= swap_pending ? fb_pkg::SYNC_SWAP : fb_pkg::SYNC_RELEASE;
                    end
                end
                fb_pkg::SYNC_SWAP:
                begin
                    // The fb_swapped level only counts once the request is out
                    if (!swap_fb && fb_swapped)
                    begin
                        state <= fb_pkg::SYNC_RELEASE;
                    end
                end
                default:
                begin
                    state <= fb_pkg::SYNC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/fb_engine_top.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_engine_top (
    input  logic                                     aclk,
    input  logic                                     rst_n,

    // Command stream
    input  logic                                     cmd_tvalid,
    output logic                                     cmd_tready,
    input  logic                                     cmd_tlast,
    input  logic [`FB_CMD_WIDTH-1:0]                 cmd_tdata,

    // One write port per buffer
    output logic [`FB_NUM_BUFFERS-1:0]               mem_wvalid,
    output fb_pkg::fb_index_t [`FB_NUM_BUFFERS-1:0]  mem_waddr,
    output fb_pkg::fb_pixel_t [`FB_NUM_BUFFERS-1:0]  mem_wdata,
    input  logic [`FB_NUM_BUFFERS-1:0]               mem_wready,

    // Display handshake
    output logic                                     swap_fb,
    output fb_pkg::fb_index_t                        fb_addr,
    input  logic                                     fb_swapped
);

    fb_pkg::fb_window_t    window;
    logic                  swap_req;
    logic                  release_apply;

    fb_unit_if unit_bus [`FB_NUM_BUFFERS] ();

    fb_cmd_decoder fb_cmd_decoder_i (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cmd_tvalid    (cmd_tvalid),
        .cmd_tready    (cmd_tready),
        .cmd_tlast     (cmd_tlast),
        .cmd_tdata     (cmd_tdata),
        .units         (unit_bus),
        .window        (window),
        .swap_req      (swap_req),
        .color_addr    (fb_addr),
        .release_apply (release_apply)
    );

    for (genvar i = 0; i < `FB_NUM_BUFFERS; i++)
    begin : g_unit
        fb_clear_unit fb_clear_unit_i (
            .aclk       (aclk),
            .rst_n      (rst_n),
            .unit       (unit_bus[i]),
            .window     (window),
            .mem_wvalid (mem_wvalid[i]),
            .mem_waddr  (mem_waddr[i]),
            .mem_wdata  (mem_wdata[i]),
            .mem_wready (mem_wready[i])
        );
    end

    fb_apply_sync fb_apply_sync_i (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .units         (unit_bus),
        .swap_req      (swap_req),
        .swap_fb       (swap_fb),
        .fb_swapped    (fb_swapped),
        .release_apply (release_apply)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

// 100 MHz clock and a reset held low for the first ten rising edges
module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #5 aclk = ~aclk;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge aclk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- verif/fb_engine_tb.sv
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_engine_tb;

    localparam int TIMEOUT = 2000;

    logic                                            aclk;
    logic                                            rst_n;
    logic                                            cmd_tvalid;
    logic                                            cmd_tready;
    logic                                            cmd_tlast;
    logic [`FB_CMD_WIDTH-1:0]                        cmd_tdata;
    logic [`FB_NUM_BUFFERS-1:0]                      mem_wvalid;
    fb_pkg::fb_index_t [`FB_NUM_BUFFERS-1:0]         mem_waddr;
    fb_pkg::fb_pixel_t [`FB_NUM_BUFFERS-1:0]         mem_wdata;
    logic [`FB_NUM_BUFFERS-1:0]                      mem_wready;
    logic                                            swap_fb;
    fb_pkg::fb_index_t                               fb_addr;
    logic                                            fb_swapped;

    integer                seed = 6196;
    integer                rnd;
    logic                  random_bp;
    int                    failures;
    int                    checks;
    int                    swap_count;

    // Write log filled by the monitor and expected writes built by the tests
    int                    got_buf [$];
    fb_pkg::fb_index_t     got_addr [$];
    fb_pkg::fb_pixel_t     got_data [$];
    int                    log_start;
    int                    exp_buf [$];
    fb_pkg::fb_index_t     exp_addr [$];
    fb_pkg::fb_pixel_t     exp_data [$];

    string                 buf_name [`FB_NUM_BUFFERS] = '{"color", "depth", "stencil"};

    tb_clock_gen tb_clock_gen_i (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    fb_engine_top fb_engine_top_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .cmd_tvalid (cmd_tvalid),
        .cmd_tready (cmd_tready),
        .cmd_tlast  (cmd_tlast),
        .cmd_tdata  (cmd_tdata),
        .mem_wvalid (mem_wvalid),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wready (mem_wready),
        .swap_fb    (swap_fb),
        .fb_addr    (fb_addr),
        .fb_swapped (fb_swapped)
    );

    // Memory responder drives ready stuck high or random per buffer
    initial
    begin
        mem_wready = '1;
        forever
        begin
            @(posedge aclk);
            #1;
            rnd = $random(seed);
            mem_wready = random_bp ? rnd[`FB_NUM_BUFFERS-1:0] : '1;
        end
    end

    // Outputs are stable at the falling edge
    initial
    begin
        swap_count = 0;
        forever
        begin
            @(negedge aclk);
            for (int b = 0; b < `FB_NUM_BUFFERS; b++)
            begin
                if (mem_wvalid[b] && mem_wready[b])
                begin
                    got_buf.push_back(b);
                    got_addr.push_back(mem_waddr[b]);
                    got_data.push_back(mem_wdata[b]);
                end
            end
            if (swap_fb)
            begin
                swap_count++;
            end
        end
    end

    task automatic check_pixel(input string name, input fb_pkg::fb_pixel_t got,
                               input fb_pkg::fb_pixel_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            failures++;
        end
    endtask

    task automatic check_index(input string name, input fb_pkg::fb_index_t got,
                               input fb_pkg::fb_index_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            failures++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            failures++;
        end
    endtask

    function automatic logic [`FB_CMD_WIDTH-1:0] pack_xy(input int x, input int y);
        logic [`FB_CMD_WIDTH-1:0] w;
        w = '0;
        w[0 +: `FB_POS_WIDTH]  = fb_pkg::fb_pos_t'(x);
        w[16 +: `FB_POS_WIDTH] = fb_pkg::fb_pos_t'(y);
        return w;
    endfunction

    // One beat held until the DUT takes it
    task automatic send_word(input logic [`FB_CMD_WIDTH-1:0] data, input logic last);
        int cycles;
        @(posedge aclk);
        #1;
        cmd_tvalid = 1'b1;
        cmd_tdata  = data;
        cmd_tlast  = last;
        cycles     = 0;
        @(negedge aclk);
        while (!cmd_tready && cycles < TIMEOUT)
        begin
            @(negedge aclk);
            cycles++;
        end
        if (!cmd_tready)
        begin
            $display("timeout: command word %h was never accepted", data);
            failures++;
        end
        @(posedge aclk);
        #1;
        cmd_tvalid = 1'b0;
        cmd_tlast  = 1'b0;
    endtask

    task automatic set_reg(input fb_pkg::fb_reg_e id, input int b,
                           input logic [`FB_CMD_WIDTH-1:0] data);
        logic [`FB_CMD_WIDTH-1:0] w;
        w = '0;
        w[31:28] = fb_pkg::OP_SET_REG;
        w[27:24] = id;
        w[17:16] = 2'(b);
        send_word(w, 1'b0);
        send_word(data, 1'b1);
    endtask

    task automatic apply(input logic [`FB_NUM_BUFFERS-1:0] mask, input logic memset,
                         input logic swap);
        logic [`FB_CMD_WIDTH-1:0] w;
        w = '0;
        w[31:28] = fb_pkg::OP_APPLY;
        w[5]     = swap;
        w[4]     = memset;
        w[2:0]   = mask;
        send_word(w, 1'b1);
    endtask

    task automatic wait_release();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (!cmd_tready && cycles < TIMEOUT)
        begin
            @(negedge aclk);
            cycles++;
        end
        if (!cmd_tready)
        begin
            $display("timeout: cmd_tready did not return high after an apply");
            failures++;
        end
    endtask

    task automatic start_log();
        log_start = got_buf.size();
        exp_buf.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    // Expected clear writes from the rectangle rules
    task automatic expect_clear(input int b, input int base, input int value, input bit scissor,
                                input int sx, input int sy, input int ex, input int ey,
                                input int rx, input int ry);
        int x_lo;
        int x_hi;
        int y_lo;
        int y_hi;
        x_lo = scissor ? ((sx > 0) ? sx : 0) : 0;
        y_lo = scissor ? ((sy > 0) ? sy : 0) : 0;
        x_hi = scissor ? ((ex < rx) ? ex : rx) : rx;
        y_hi = scissor ? ((ey < ry) ? ey : ry) : ry;
        for (int y = y_lo; y < y_hi; y++)
        begin
            for (int x = x_lo; x < x_hi; x++)
            begin
                exp_buf.push_back(b);
                exp_addr.push_back(fb_pkg::fb_index_t'(base + y * rx + x));
                exp_data.push_back(fb_pkg::fb_pixel_t'(value));
            end
        end
    endtask

    task automatic compare_writes();
        fb_pkg::fb_index_t ga [$];
        fb_pkg::fb_pixel_t gd [$];
        fb_pkg::fb_index_t ea [$];
        fb_pkg::fb_pixel_t ed [$];
        int n;
        for (int b = 0; b < `FB_NUM_BUFFERS; b++)
        begin
            ga.delete();
            gd.delete();
            ea.delete();
            ed.delete();
            for (int k = log_start; k < got_buf.size(); k++)
            begin
                if (got_buf[k] == b)
                begin
                    ga.push_back(got_addr[k]);
                    gd.push_back(got_data[k]);
                end
            end
            for (int k = 0; k < exp_buf.size(); k++)
            begin
                if (exp_buf[k] == b)
                begin
                    ea.push_back(exp_addr[k]);
                    ed.push_back(exp_data[k]);
                end
            end
            if (ga.size() != ea.size())
            begin
                $display("%s buffer received %0d writes but %0d were expected",
                         buf_name[b], ga.size(), ea.size());
                failures++;
            end
            n = (ga.size() < ea.size()) ? ga.size() : ea.size();
            for (int k = 0; k < n; k++)
            begin
                check_index($sformatf("mem_waddr[%0d]", b), ga[k], ea[k]);
                check_pixel($sformatf("mem_wdata[%0d]", b), gd[k], ed[k]);
            end
        end
    endtask

    task automatic report_test(input string name, input int start_failures);
        $display("%-20s %s", name, (failures == start_failures) ? "ok" : "FAILED");
    endtask

    task automatic test_reset_state();
        int start;
        start = failures;
        @(negedge aclk);
        check_bit("cmd_tready", cmd_tready, 1'b1);
        check_bit("swap_fb", swap_fb, 1'b0);
        for (int b = 0; b < `FB_NUM_BUFFERS; b++)
        begin
            check_bit($sformatf("mem_wvalid[%0d]", b), mem_wvalid[b], 1'b0);
        end
        report_test("reset_state", start);
    endtask

    task automatic test_full_memset();
        int start;
        start = failures;
        set_reg(fb_pkg::REG_RESOLUTION, 0, pack_xy(4, 3));
        set_reg(fb_pkg::REG_ADDR, 1, 32'h100);
        set_reg(fb_pkg::REG_CLEAR, 1, 32'hA5C3);
        start_log();
        expect_clear(1, 'h100, 'hA5C3, 1'b0, 0, 0, 0, 0, 4, 3);
        apply(3'b010, 1'b1, 1'b0);
        // The stream blocks in the cycle after the apply beat
        @(negedge aclk);
        check_bit("cmd_tready", cmd_tready, 1'b0);
        wait_release();
        compare_writes();
        report_test("full_memset", start);
    endtask

    task automatic test_scissor_memset();
        int start;
        start = failures;
        set_reg(fb_pkg::REG_ADDR, 0, 32'h2000);
        set_reg(fb_pkg::REG_CLEAR, 0, 32'h1234);
        set_reg(fb_pkg::REG_SCISSOR_START, 0, pack_xy(1, 1));
        set_reg(fb_pkg::REG_SCISSOR_END, 0, pack_xy(3, 9));
        set_reg(fb_pkg::REG_SCISSOR_EN, 0, 32'h1);
        start_log();
        expect_clear(0, 'h2000, 'h1234, 1'b1, 1, 1, 3, 9, 4, 3);
        apply(3'b001, 1'b1, 1'b0);
        wait_release();
        compare_writes();
        report_test("scissor_memset", start);
    endtask

    task automatic test_three_buffers();
        int start;
        start = failures;
        set_reg(fb_pkg::REG_SCISSOR_EN, 0, 32'h0);
        set_reg(fb_pkg::REG_RESOLUTION, 0, pack_xy(5, 4));
        set_reg(fb_pkg::REG_ADDR, 0, 32'h3000);
        set_reg(fb_pkg::REG_ADDR, 1, 32'h4000);
        set_reg(fb_pkg::REG_ADDR, 2, 32'h5000);
        set_reg(fb_pkg::REG_CLEAR, 0, 32'hF800);
        set_reg(fb_pkg::REG_CLEAR, 1, 32'hFFFF);
        set_reg(fb_pkg::REG_CLEAR, 2, 32'h00FF);
        set_reg(fb_pkg::REG_MASK, 2, 32'h0);
        start_log();
        // Stencil is write protected, so only color and depth expect writes
        expect_clear(0, 'h3000, 'hF800, 1'b0, 0, 0, 0, 0, 5, 4);
        expect_clear(1, 'h4000, 'hFFFF, 1'b0, 0, 0, 0, 0, 5, 4);
        random_bp = 1'b1;
        apply(3'b111, 1'b1, 1'b0);
        wait_release();
        random_bp = 1'b0;
        compare_writes();
        report_test("three_buffers", start);
    endtask

    task automatic test_swap_exchange();
        int start;
        int swap_start;
        int cycles;
        start      = failures;
        set_reg(fb_pkg::REG_ADDR, 0, 32'hABCDE);
        swap_start = swap_count;
        apply(3'b001, 1'b0, 1'b1);
        cycles = 0;
        while (swap_fb !== 1'b1 && cycles < TIMEOUT)
        begin
            @(negedge aclk);
            cycles++;
        end
        if (swap_fb !== 1'b1)
        begin
            $display("timeout: swap_fb was never raised");
            failures++;
        end
        else
        begin
            check_index("fb_addr", fb_addr, 20'hABCDE);
        end
        // Display has not confirmed yet, so the stream stays blocked
        repeat (20)
        begin
            @(negedge aclk);
            check_bit("cmd_tready", cmd_tready, 1'b0);
        end
        @(posedge aclk);
        #1;
        fb_swapped = 1'b1;
        wait_release();
        @(posedge aclk);
        #1;
        fb_swapped = 1'b0;
        if (swap_count - swap_start != 1)
        begin
            $display("swap_fb pulsed %0d times instead of once", swap_count - swap_start);
            failures++;
        end
        report_test("swap_exchange", start);
    endtask

    initial
    begin
        int cycles;
        cmd_tvalid = 1'b0;
        cmd_tlast  = 1'b0;
        cmd_tdata  = '0;
        fb_swapped = 1'b0;
        random_bp  = 1'b0;
        failures   = 0;
        checks     = 0;
        log_start  = 0;
        cycles     = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT)
        begin
            @(posedge aclk);
            cycles++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("reset was never released");
            failures++;
        end
        test_reset_state();
        test_full_memset();
        test_scissor_memset();
        test_three_buffers();
        test_swap_exchange();
        $display("%0d checks, %0d failures", checks, failures);
        if (failures == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hw/fb_pkg.sv
hw/fb_unit_if.sv
hw/fb_cmd_decoder.sv
hw/fb_clear_unit.sv
hw/fb_apply_sync.sv
hw/fb_engine_top.sv
verif/tb_clock_gen.sv
verif/fb_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the framebuffer engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -Iinclude -f build.f \
    --top-module fb_engine_tb --Mdir obj_dir -o fb_engine_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fb_engine_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
